// ==== Makefile ====
# Verilator build and run of the QLA register bus core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module fpga_qla_tb -o fpga_qla_sim
	./obj_dir/fpga_qla_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== include/qla_consts.svh ====
// register bus constants for the QLA board core
// address spaces, register offsets, axis count and safety trip length
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// ----------------------------------------------------------------------
// address map, addr[15:12] space, addr[7:4] channel, addr[3:0] offset
// ----------------------------------------------------------------------
`define QLA_SPACE_MAIN     4'h0   // board + per-axis registers
`define QLA_SPACE_HUB      4'h2   // hub quadlet memory

`define QLA_CHAN_BOARD     4'h0   // channel 0 holds board i/o

`define QLA_OFF_STATUS     4'h0   // board status / control
`define QLA_OFF_DAC_CTRL   4'h1   // current command, channels 1..4

// ----------------------------------------------------------------------
// sizes
// ----------------------------------------------------------------------
`define QLA_NUM_AXES       4
`define QLA_HUB_DEPTH      16     // quadlets

// consecutive over-current samples before the amp is cut
`define QLA_SAFETY_CYCLES  4

`endif

// ==== rtl/board_regs.sv ====
// channel 0 board registers
// status / control word, enable command pulses, registered amp disable
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module board_regs (
    input  wire                      sysclk,
    input  wire                      rst,
    input  wire                      wsel,            // decoded channel-0 write
    input  qla_bus_pkg::reg_addr_t   waddr,
    input  qla_bus_pkg::reg_data_t   wdata,
    input  qla_bus_pkg::reg_addr_t   raddr,
    input  wire [3:0]                board_id,        // rotary switch
    input  qla_axis_pkg::axis_mask_t safety_disable,  // from the safety checks
    output qla_bus_pkg::reg_data_t   rdata,
    output logic                     pwr_enable,
    output qla_axis_pkg::axis_mask_t amp_disable,
    output logic                     pwr_enable_cmd,  // one-cycle pulses
    output qla_axis_pkg::axis_mask_t amp_enable_cmd
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    axis_mask_t amp_enable;
    logic       status_wr;
    reg_data_t  status;

    assign status_wr = wsel && (waddr[3:0] == `QLA_OFF_STATUS);

    // ------------------------------------------------------------------
    // control bits and command pulses
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            amp_enable     <= '0;
            pwr_enable     <= 1'b0;
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= '0;
        end else begin
            if (status_wr) begin
                amp_enable <= wdata[3:0];
                pwr_enable <= wdata[8];
            end
            // pulses drop again unless rewritten
            pwr_enable_cmd <= status_wr & wdata[8];
            amp_enable_cmd <= status_wr ? wdata[3:0] : '0;
        end
    end

    // amp output, off unless enabled and not tripped
    always_ff @(posedge sysclk) begin
        if (rst)
            amp_disable <= '1;   // amps off out of reset
        else
            amp_disable <= ~amp_enable | safety_disable;
    end

    // ------------------------------------------------------------------
    // readback
    // ------------------------------------------------------------------
    assign status = {4'h0, board_id,    // 31..24
                     15'h0, pwr_enable, // 23..8
                     safety_disable,    // 7..4
                     amp_enable};       // 3..0

    assign rdata = (raddr[3:0] == `QLA_OFF_STATUS) ? status : '0;

endmodule

`default_nettype wire

// ==== rtl/dac_regs.sv ====
// per-axis current command registers
// written through channels 1..4, offset DAC_CTRL
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module dac_regs (
    input  wire                    sysclk,
    input  wire                    rst,
    input  wire                    wsel,      // decoded axis-channel write
    input  qla_bus_pkg::reg_addr_t waddr,
    input  qla_bus_pkg::reg_data_t wdata,
    input  qla_bus_pkg::reg_addr_t raddr,
    output qla_bus_pkg::reg_data_t rdata,
    output qla_axis_pkg::cur_t     cur_cmd [`QLA_NUM_AXES]
);
    import qla_axis_pkg::*;

    localparam int IW = $clog2(`QLA_NUM_AXES);

    logic [3:0] wchan_m1, rchan_m1;   // channel n -> axis index n-1
    logic       rd_hit;
    cur_t       rd_cmd;

    assign wchan_m1 = waddr[7:4] - 4'd1;
    assign rchan_m1 = raddr[7:4] - 4'd1;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++)
                cur_cmd[i] <= '0;
        end else if (wsel && waddr[3:0] == `QLA_OFF_DAC_CTRL) begin
            cur_cmd[wchan_m1[IW-1:0]] <= wdata[15:0];
        end
    end

    // readback only on axis channels at the command offset
    assign rd_hit = (raddr[3:0] == `QLA_OFF_DAC_CTRL) && (raddr[7:4] != 4'd0)
                    && (raddr[7:4] <= 4'(`QLA_NUM_AXES));
    assign rd_cmd = cur_cmd[rchan_m1[IW-1:0]];
    assign rdata  = rd_hit ? {16'h0, rd_cmd} : '0;

endmodule

`default_nettype wire

// ==== rtl/fpga_qla_top.sv ====
// QLA register bus core top level
// router, hub memory, board and dac registers, per-axis safety checks
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module fpga_qla_top (
    input  wire                      sysclk,
    input  wire                      rst,
    input  wire [3:0]                board_id,
    // firewire master
    input  wire                      fw_reg_wen,
    input  qla_bus_pkg::reg_addr_t   fw_reg_waddr,
    input  qla_bus_pkg::reg_data_t   fw_reg_wdata,
    input  qla_bus_pkg::reg_addr_t   fw_reg_raddr,
    // ethernet master
    input  wire                      eth_reg_wen,
    input  qla_bus_pkg::reg_addr_t   eth_reg_waddr,
    input  qla_bus_pkg::reg_data_t   eth_reg_wdata,
    input  qla_bus_pkg::reg_addr_t   eth_reg_raddr,
    input  wire                      eth_read_en,
    input  qla_axis_pkg::cur_t       cur_fb [`QLA_NUM_AXES],  // adc feedback
    output qla_bus_pkg::reg_data_t   reg_rdata,
    output logic                     pwr_enable,
    output qla_axis_pkg::axis_mask_t amp_disable,
    output qla_axis_pkg::axis_mask_t safety_amp_disable
);
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    // merged bus
    reg_addr_t  reg_waddr, reg_raddr;
    reg_data_t  reg_wdata;
    logic       hub_wsel, board_wsel, dac_wsel;
    reg_data_t  hub_rdata, board_rdata, dac_rdata;

    // enable command pulses that clear the safety latches
    logic       pwr_enable_cmd;
    axis_mask_t amp_enable_cmd;
    cur_t       cur_cmd [`QLA_NUM_AXES];

    // ------------------------------------------------------------------
    // bus and slaves
    // ------------------------------------------------------------------
    reg_bus_router router (
        .fw_reg_wen, .fw_reg_waddr, .fw_reg_wdata, .fw_reg_raddr,
        .eth_reg_wen, .eth_reg_waddr, .eth_reg_wdata, .eth_reg_raddr, .eth_read_en,
        .hub_rdata, .board_rdata, .dac_rdata,
        .reg_waddr, .reg_wdata, .reg_wen(), .reg_raddr,
        .hub_wsel, .board_wsel, .dac_wsel, .reg_rdata
    );

    hub_mem hub (
        .sysclk, .rst, .wsel(hub_wsel), .waddr(reg_waddr), .wdata(reg_wdata),
        .raddr(reg_raddr), .rdata(hub_rdata)
    );

    board_regs chan0 (
        .sysclk, .rst, .wsel(board_wsel), .waddr(reg_waddr), .wdata(reg_wdata),
        .raddr(reg_raddr), .board_id, .safety_disable(safety_amp_disable),
        .rdata(board_rdata), .pwr_enable, .amp_disable,
        .pwr_enable_cmd, .amp_enable_cmd
    );

    dac_regs dac (
        .sysclk, .rst, .wsel(dac_wsel), .waddr(reg_waddr), .wdata(reg_wdata),
        .raddr(reg_raddr), .rdata(dac_rdata), .cur_cmd
    );

    // ------------------------------------------------------------------
    // one safety checker per axis
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_safety
        safety_check safe (
            .sysclk, .rst,
            .cur_fb(cur_fb[i]),
            .cur_cmd(cur_cmd[i]),
            .clear_disable(pwr_enable_cmd | amp_enable_cmd[i]),
            .safety_disable(safety_amp_disable[i])
        );
    end

endmodule

`default_nettype wire

// ==== rtl/hub_mem.sv ====
// hub quadlet memory
// write on select, combinational read, unwritten words read zero
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module hub_mem (
    input  wire                    sysclk,
    input  wire                    rst,
    input  wire                    wsel,
    input  qla_bus_pkg::reg_addr_t waddr,
    input  qla_bus_pkg::reg_data_t wdata,
    input  qla_bus_pkg::reg_addr_t raddr,
    output qla_bus_pkg::reg_data_t rdata
);
    import qla_bus_pkg::*;

    localparam int AW = $clog2(`QLA_HUB_DEPTH);

    reg_data_t                 mem [`QLA_HUB_DEPTH];
    logic [`QLA_HUB_DEPTH-1:0] valid;   // word written since reset

    always_ff @(posedge sysclk) begin
        if (wsel)
            mem[waddr[AW-1:0]] <= wdata;
    end

    always_ff @(posedge sysclk) begin
        if (rst)
            valid <= '0;
        else if (wsel)
            valid[waddr[AW-1:0]] <= 1'b1;
    end

    assign rdata = valid[raddr[AW-1:0]] ? mem[raddr[AW-1:0]] : '0;

endmodule

`default_nettype wire

// ==== rtl/qla_axis_pkg.sv ====
// motor axis types
// current values and one-bit-per-axis masks
`default_nettype none

package qla_axis_pkg;

`include "qla_consts.svh"

    typedef logic [15:0] cur_t;   // unsigned current, dac / adc counts

    // bit 0 is axis 1
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;

endpackage

`default_nettype wire

// ==== rtl/qla_bus_pkg.sv ====
// register bus types
// address, quadlet data and address-space codes
`default_nettype none

package qla_bus_pkg;

`include "qla_consts.svh"

    typedef logic [15:0] reg_addr_t;   // space | xx | channel | offset
    typedef logic [31:0] reg_data_t;   // one quadlet

    // only the spaces this core decodes
    typedef enum logic [3:0] {
        SPACE_MAIN = `QLA_SPACE_MAIN,
        SPACE_HUB  = `QLA_SPACE_HUB
    } addr_space_t;

endpackage

`default_nettype wire

// ==== rtl/reg_bus_router.sv ====
// register bus router
// merges firewire and ethernet masters, decodes write selects, muxes reads
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module reg_bus_router (
    // firewire master
    input  wire                    fw_reg_wen,
    input  qla_bus_pkg::reg_addr_t fw_reg_waddr,
    input  qla_bus_pkg::reg_data_t fw_reg_wdata,
    input  qla_bus_pkg::reg_addr_t fw_reg_raddr,
    // ethernet master
    input  wire                    eth_reg_wen,
    input  qla_bus_pkg::reg_addr_t eth_reg_waddr,
    input  qla_bus_pkg::reg_data_t eth_reg_wdata,
    input  qla_bus_pkg::reg_addr_t eth_reg_raddr,
    input  wire                    eth_read_en,    // eth owns the read address
    // slave read data
    input  qla_bus_pkg::reg_data_t hub_rdata,
    input  qla_bus_pkg::reg_data_t board_rdata,
    input  qla_bus_pkg::reg_data_t dac_rdata,
    // merged bus
    output qla_bus_pkg::reg_addr_t reg_waddr,
    output qla_bus_pkg::reg_data_t reg_wdata,
    output logic                   reg_wen,
    output qla_bus_pkg::reg_addr_t reg_raddr,
    output logic                   hub_wsel,
    output logic                   board_wsel,
    output logic                   dac_wsel,
    output qla_bus_pkg::reg_data_t reg_rdata
);
    import qla_bus_pkg::*;

    addr_space_t wspace, rspace;
    logic [3:0]  wchan, rchan;
    logic        wchan_axis, rchan_axis;   // channel 1..NUM_AXES

    // ------------------------------------------------------------------
    // master merge, ethernet wins a write collision
    // ------------------------------------------------------------------
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
    assign reg_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
    assign reg_wen   = fw_reg_wen | eth_reg_wen;

    assign wspace = addr_space_t'(reg_waddr[15:12]);
    assign rspace = addr_space_t'(reg_raddr[15:12]);
    assign wchan  = reg_waddr[7:4];
    assign rchan  = reg_raddr[7:4];

    assign wchan_axis = (wchan != 4'd0) && (wchan <= 4'(`QLA_NUM_AXES));
    assign rchan_axis = (rchan != 4'd0) && (rchan <= 4'(`QLA_NUM_AXES));

    // write selects, slaves never look at the space bits
    assign hub_wsel   = reg_wen && (wspace == SPACE_HUB);
    assign board_wsel = reg_wen && (wspace == SPACE_MAIN) && (wchan == `QLA_CHAN_BOARD);
    assign dac_wsel   = reg_wen && (wspace == SPACE_MAIN) && wchan_axis;

    // read mux, unmapped reads as zero
    always_comb begin
        if (rspace == SPACE_HUB)
            reg_rdata = hub_rdata;
        else if (rspace == SPACE_MAIN && rchan == `QLA_CHAN_BOARD)
            reg_rdata = board_rdata;
        else if (rspace == SPACE_MAIN && rchan_axis)
            reg_rdata = dac_rdata;
        else
            reg_rdata = '0;
    end

endmodule

`default_nettype wire

// ==== rtl/safety_check.sv ====
// single-axis over-current check
// trips when feedback exceeds twice the command for SAFETY_CYCLES samples
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module safety_check (
    input  wire                sysclk,
    input  wire                rst,
    input  qla_axis_pkg::cur_t cur_fb,         // measured current
    input  qla_axis_pkg::cur_t cur_cmd,        // commanded current
    input  wire                clear_disable,  // power or amp enable command
    output logic               safety_disable
);
    localparam int CNT_W = $clog2(`QLA_SAFETY_CYCLES);
    localparam logic [CNT_W-1:0] TRIP_CNT = CNT_W'(`QLA_SAFETY_CYCLES - 1);

    logic [16:0]      fb_ext, limit;
    logic             fault;
    logic [CNT_W-1:0] fault_cnt;   // consecutive faults already seen

    assign fb_ext = {1'b0, cur_fb};
    assign limit  = {cur_cmd, 1'b0};   // 2 * cmd, no overflow at 17 bits
    assign fault  = fb_ext > limit;

    always_ff @(posedge sysclk) begin
        if (rst || clear_disable) begin   // clear wins over a fault
            fault_cnt      <= '0;
            safety_disable <= 1'b0;
        end else if (fault) begin
            if (fault_cnt == TRIP_CNT)
                safety_disable <= 1'b1;      // latched until cleared
            else
                fault_cnt <= fault_cnt + 1'b1;
        end else begin
            fault_cnt <= '0;                 // run broken
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
rtl/qla_bus_pkg.sv
rtl/qla_axis_pkg.sv
rtl/reg_bus_router.sv
rtl/hub_mem.sv
rtl/board_regs.sv
rtl/dac_regs.sv
rtl/safety_check.sv
rtl/fpga_qla_top.sv
tb/fpga_qla_chk.sv
tb/fpga_qla_tb.sv

// ==== tb/fpga_qla_chk.sv ====
// bound assertions for the QLA core
// reset state of the amps, safety trip history, command pulse width
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module fpga_qla_chk (
    input wire                      sysclk,
    input wire                      rst,
    input qla_axis_pkg::cur_t       cur_fb [`QLA_NUM_AXES],
    input qla_axis_pkg::cur_t       cur_cmd [`QLA_NUM_AXES],
    input qla_axis_pkg::axis_mask_t amp_disable,
    input qla_axis_pkg::axis_mask_t safety_amp_disable,
    input wire                      pwr_enable_cmd,
    input qla_axis_pkg::axis_mask_t amp_enable_cmd
);
    import qla_axis_pkg::*;

    axis_mask_t fault;   // feedback above twice the command

    // amps off right out of reset
    a_reset_off: assert property (@(posedge sysclk) $fell(rst) |-> amp_disable == '1)
        else $error("amp_disable not all ones after reset");

    // ------------------------------------------------------------------
    // per axis, a trip needs four fault samples in a row
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        assign fault[i] = {1'b0, cur_fb[i]} > {cur_cmd[i], 1'b0};

        a_trip_history: assert property (@(posedge sysclk) disable iff (rst)
            $rose(safety_amp_disable[i]) |-> $past(fault[i], 1) && $past(fault[i], 2)
                && $past(fault[i], 3) && $past(fault[i], 4))
            else $error("axis %0d tripped without four fault samples", i + 1);
    end

    // enable commands are single-cycle pulses
    a_pwr_pulse: assert property (@(posedge sysclk) disable iff (rst)
        pwr_enable_cmd |=> !pwr_enable_cmd)
        else $error("pwr_enable_cmd high for more than one cycle");

    a_amp_pulse: assert property (@(posedge sysclk) disable iff (rst)
        (|amp_enable_cmd) |=> (amp_enable_cmd == '0))
        else $error("amp_enable_cmd high for more than one cycle");

endmodule

bind fpga_qla_top fpga_qla_chk chk (
    .sysclk(sysclk), .rst(rst), .cur_fb(cur_fb), .cur_cmd(cur_cmd),
    .amp_disable(amp_disable), .safety_amp_disable(safety_amp_disable),
    .pwr_enable_cmd(pwr_enable_cmd), .amp_enable_cmd(amp_enable_cmd)
);

`default_nettype wire

// ==== tb/fpga_qla_tb.sv ====
// testbench for the QLA register bus core
// clock, reset, bus stimulus, reference model, compare process and report
`timescale 1ns/1ns
`default_nettype none

`include "qla_consts.svh"

module fpga_qla_tb;
    import qla_bus_pkg::*;
    import qla_axis_pkg::*;

    localparam logic [3:0] BOARD_ID   = 4'hA;
    localparam int         MAX_CYCLES = 2000;   // tests need about 250 cycles

    logic       sysclk, rst;
    logic       fw_reg_wen, eth_reg_wen, eth_read_en;
    reg_addr_t  fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr;
    reg_data_t  fw_reg_wdata, eth_reg_wdata, reg_rdata;
    cur_t       cur_fb [`QLA_NUM_AXES];
    logic       pwr_enable;
    axis_mask_t amp_disable, safety_amp_disable;

    // reference model state
    reg_data_t  m_hub [`QLA_HUB_DEPTH];
    cur_t       m_dac [16];     // indexed by channel 1..4
    logic       m_pwr;
    axis_mask_t m_amp, m_safe;

    // requests from stimulus to the compare process
    logic       rd_chk, out_chk, exp_pwr;
    reg_addr_t  chk_addr;
    reg_data_t  exp_rdata;
    axis_mask_t exp_ampdis, exp_safe;
    int         errors = 0, err_mark = 0, tests_run = 0, tests_failed = 0, cycles = 0;
    int         seed;

    fpga_qla_top uut (
        .sysclk, .rst, .board_id(BOARD_ID),
        .fw_reg_wen, .fw_reg_waddr, .fw_reg_wdata, .fw_reg_raddr,
        .eth_reg_wen, .eth_reg_waddr, .eth_reg_wdata, .eth_reg_raddr, .eth_read_en,
        .cur_fb, .reg_rdata, .pwr_enable, .amp_disable, .safety_amp_disable
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic reg_data_t ref_read(input reg_addr_t a);
        logic [3:0] sp, ch, off;
        sp  = a[15:12];
        ch  = a[7:4];
        off = a[3:0];
        if (sp == `QLA_SPACE_HUB)
            return m_hub[off];
        if (sp != `QLA_SPACE_MAIN)
            return '0;                       // unmapped space
        if (ch == 4'd0)                      // board status word
            return (off == `QLA_OFF_STATUS) ?
                   {4'h0, BOARD_ID, 15'h0, m_pwr, m_safe, m_amp} : '0;
        if (ch <= 4'(`QLA_NUM_AXES) && off == `QLA_OFF_DAC_CTRL)
            return {16'h0, m_dac[ch]};
        return '0;
    endfunction

    function automatic void model_write(input reg_addr_t a, input reg_data_t d);
        if (a[15:12] == `QLA_SPACE_HUB) begin
            m_hub[a[3:0]] = d;
        end else if (a[15:12] == `QLA_SPACE_MAIN && a[7:4] == 4'd0) begin
            if (a[3:0] == `QLA_OFF_STATUS) begin
                m_amp  = d[3:0];
                m_pwr  = d[8];
                m_safe = d[8] ? '0 : (m_safe & ~d[3:0]);   // enable cmds clear trips
            end
        end else if (a[15:12] == `QLA_SPACE_MAIN && a[7:4] <= 4'(`QLA_NUM_AXES)) begin
            if (a[3:0] == `QLA_OFF_DAC_CTRL)
                m_dac[a[7:4]] = d[15:0];
        end
    endfunction

    // ------------------------------------------------------------------
    // compare process on the falling edge
    // ------------------------------------------------------------------
    always @(negedge sysclk) begin
        if (rd_chk && reg_rdata !== exp_rdata) begin
            $display("** Error @ %0t: read %h got %h exp %h", $time, chk_addr,
                     reg_rdata, exp_rdata);
            errors++;
        end
        if (out_chk && pwr_enable !== exp_pwr) begin
            $display("** Error @ %0t: pwr_enable got %b exp %b", $time, pwr_enable, exp_pwr);
            errors++;
        end
        if (out_chk && amp_disable !== exp_ampdis) begin
            $display("** Error @ %0t: amp_disable got %b exp %b", $time,
                     amp_disable, exp_ampdis);
            errors++;
        end
        if (out_chk && safety_amp_disable !== exp_safe) begin
            $display("** Error @ %0t: safety_amp_disable got %b exp %b", $time,
                     safety_amp_disable, exp_safe);
            errors++;
        end
    end

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------------
    task automatic bus_write(input logic eth, input reg_addr_t a, input reg_data_t d);
        @(posedge sysclk);
        if (eth) begin
            eth_reg_wen   <= 1'b1;
            eth_reg_waddr <= a;
            eth_reg_wdata <= d;
        end else begin
            fw_reg_wen   <= 1'b1;
            fw_reg_waddr <= a;
            fw_reg_wdata <= d;
        end
        @(posedge sysclk);                   // capture edge
        fw_reg_wen  <= 1'b0;
        eth_reg_wen <= 1'b0;
        model_write(a, d);
    endtask

    // the other master's read address points one word away
    task automatic read_check(input logic eth, input reg_addr_t a);
        @(posedge sysclk);
        eth_read_en   <= eth;
        eth_reg_raddr <= eth ? a : (a ^ 16'h0001);
        fw_reg_raddr  <= eth ? (a ^ 16'h0001) : a;
        chk_addr  <= a;
        exp_rdata <= ref_read(a);
        rd_chk    <= 1'b1;
        @(posedge sysclk);
        rd_chk <= 1'b0;
    endtask

    task automatic check_outputs(input int delay);
        repeat (delay) @(posedge sysclk);
        exp_pwr    <= m_pwr;
        exp_ampdis <= ~m_amp | m_safe;
        exp_safe   <= m_safe;
        out_chk    <= 1'b1;
        @(posedge sysclk);
        out_chk <= 1'b0;
    endtask

    // hold feedback for n cycles and drop it to zero
    task automatic apply_current(input logic [1:0] axis, input cur_t fb, input int n,
                                 input logic trips);
        axis_mask_t bitm;
        bitm = 4'b0001 << axis;
        @(posedge sysclk);
        cur_fb[axis] <= fb;
        for (int k = 1; k <= n; k++) begin
            @(posedge sysclk);
            if (k == n)
                cur_fb[axis] <= '0;
            exp_pwr    <= m_pwr;
            exp_safe   <= m_safe | ((trips && k >= `QLA_SAFETY_CYCLES) ? bitm : 4'b0);
            exp_ampdis <= ~m_amp | m_safe |
                          ((trips && k > `QLA_SAFETY_CYCLES) ? bitm : 4'b0);  // one later
            out_chk    <= 1'b1;
        end
        @(posedge sysclk);
        out_chk <= 1'b0;
        if (trips)
            m_safe = m_safe | bitm;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("test %-16s FAILED with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        reg_data_t wa, wb;
        cur_t      c_trip, c_edge;
        seed = $urandom(97);
        rst = 1'b1;
        fw_reg_wen = 1'b0;
        eth_reg_wen = 1'b0;
        eth_read_en = 1'b0;
        fw_reg_waddr = '0;
        fw_reg_wdata = '0;
        fw_reg_raddr = '0;
        eth_reg_waddr = '0;
        eth_reg_wdata = '0;
        eth_reg_raddr = '0;
        rd_chk = 1'b0;
        out_chk = 1'b0;
        exp_pwr = 1'b0;
        exp_ampdis = '1;
        exp_safe = '0;
        exp_rdata = '0;
        chk_addr = '0;
        for (int i = 0; i < `QLA_NUM_AXES; i++)
            cur_fb[i] = '0;
        for (int i = 0; i < `QLA_HUB_DEPTH; i++)
            m_hub[i] = '0;
        for (int i = 0; i < 16; i++)
            m_dac[i] = '0;
        m_pwr = 1'b0;
        m_amp = '0;
        m_safe = '0;
        repeat (2) @(posedge sysclk);
        rst <= 1'b0;

        // unwritten hub word, then firewire fills and ethernet overwrites every other quadlet
        read_check(1'b0, {`QLA_SPACE_HUB, 8'h00, 4'd9});
        for (int i = 0; i < `QLA_HUB_DEPTH; i++)
            bus_write(1'b0, {`QLA_SPACE_HUB, 8'h00, 4'(i)}, $urandom);
        for (int i = 0; i < `QLA_HUB_DEPTH; i += 2)
            bus_write(1'b1, {`QLA_SPACE_HUB, 8'h00, 4'(i)}, $urandom);
        for (int i = 0; i < `QLA_HUB_DEPTH; i++) begin
            read_check(1'b0, {`QLA_SPACE_HUB, 8'h00, 4'(i)});
            read_check(1'b1, {`QLA_SPACE_HUB, 8'h00, 4'(i)});
        end
        finish_test("hub_mem");

        // both masters write in one cycle and ethernet wins
        wa = $urandom;
        wb = $urandom;
        @(posedge sysclk);
        fw_reg_wen    <= 1'b1;
        fw_reg_waddr  <= 16'h2003;
        fw_reg_wdata  <= wa;
        eth_reg_wen   <= 1'b1;
        eth_reg_waddr <= 16'h2005;
        eth_reg_wdata <= wb;
        @(posedge sysclk);
        fw_reg_wen  <= 1'b0;
        eth_reg_wen <= 1'b0;
        model_write(16'h2005, wb);
        read_check(1'b0, 16'h2003);          // firewire data must not land
        read_check(1'b0, 16'h2005);
        read_check(1'b1, 16'h2005);
        finish_test("master_merge");

        // dac commands on channels 1..4 then unmapped reads
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++)
            bus_write(ch[0], {8'h00, 4'(ch), `QLA_OFF_DAC_CTRL}, $urandom);
        for (int ch = 1; ch <= `QLA_NUM_AXES; ch++)
            read_check(ch[1], {8'h00, 4'(ch), `QLA_OFF_DAC_CTRL});
        read_check(1'b0, 16'h1000);
        read_check(1'b1, 16'h3005);
        read_check(1'b0, 16'h0051);          // channel past the last axis
        read_check(1'b1, 16'h0012);          // other dac offset
        read_check(1'b0, 16'h0002);
        finish_test("dac_unmapped");

        // power and all amps on
        bus_write(1'b0, 16'h0000, 32'h0000_010F);
        check_outputs(1);
        read_check(1'b1, 16'h0000);
        finish_test("board_reg");

        // axis 2 over current with fb = 2C + 1
        c_trip = 16'h0100;
        bus_write(1'b1, 16'h0021, {16'h0, c_trip});
        apply_current(2'd1, c_trip * 16'd2 + 16'd1, 6, 1'b1);
        read_check(1'b0, 16'h0000);          // trip shows in bits 7..4
        finish_test("safety_trip");

        // axis 3 at the limit, then two runs one sample short with a gap between
        c_edge = 16'h0080;
        bus_write(1'b0, 16'h0031, {16'h0, c_edge});
        apply_current(2'd2, c_edge * 16'd2, 8, 1'b0);
        apply_current(2'd2, c_edge * 16'd2 + 16'd1, 3, 1'b0);
        apply_current(2'd2, c_edge * 16'd2 + 16'd1, 3, 1'b0);
        check_outputs(2);
        finish_test("safety_no_trip");

        // clear by amp enable bit, trip again, clear by power enable
        bus_write(1'b0, 16'h0000, 32'h0000_0002);
        check_outputs(2);
        read_check(1'b1, 16'h0000);
        apply_current(2'd1, c_trip * 16'd2 + 16'd1, 6, 1'b1);
        bus_write(1'b1, 16'h0000, 32'h0000_0100);
        check_outputs(2);
        read_check(1'b0, 16'h0000);
        finish_test("safety_clear");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
